// ==== include/conv_defs.svh ====
`ifndef CONV_DEFS_SVH
`define CONV_DEFS_SVH

// frame and kernel geometry
`define IMG_W       8
`define IMG_H       8
`define KSZ         3
`define OUT_W       6
`define NUM_OF      4

// datapath widths
`define PIX_W       8
`define ACC_W       20
`define BIAS_W      16

// AXI4-Lite
`define ADDR_W      12
`define DATA_W      32

////////////////////////////////////////
// register map
`define REG_CTRL    12'h000
`define REG_STATUS  12'h004
`define REG_QUANT   12'h008
`define BIAS_BASE   12'h010  // one word per channel
`define WGT_BASE    12'h100  // ch*0x40 + tap*4, taps row-major
`define FRAME_BASE  12'h400  // pixel*4
`define RES_BASE    12'h800  // (pos*4 + ch)*4

`endif

// ==== hdl/conv_pkg.sv ====
`include "conv_defs.svh"

package conv_pkg;

    typedef struct packed {
        logic [`ADDR_W-1:0] awaddr;
        logic               awvalid;
        logic [`DATA_W-1:0] wdata;
        logic               wvalid;
        logic               bready;
        logic [`ADDR_W-1:0] araddr;
        logic               arvalid;
        logic               rready;
    } axil_req_t;

    typedef struct packed {
        logic               awready;
        logic               wready;
        logic               bvalid;
        logic [1:0]         bresp;
        logic               arready;
        logic               rvalid;
        logic [`DATA_W-1:0] rdata;
        logic [1:0]         rresp;
    } axil_rsp_t;

    typedef struct packed {
        logic                             valid;
        logic [5:0]                       pos;  // output position row*6 + col
        logic [`KSZ*`KSZ-1:0][`PIX_W-1:0] pix;  // tap r*3+c
    } window_t;

    // weights are signed, taken with $signed at use
    typedef logic [`NUM_OF-1:0][`KSZ*`KSZ-1:0][`PIX_W-1:0] weight_set_t;
    typedef logic [`NUM_OF-1:0][`BIAS_W-1:0] bias_vec_t;

    typedef struct packed {
        logic [3:0] shift;
        logic [7:0] scale;
    } quant_cfg_t;

    typedef struct packed {
        logic                            valid;
        logic [5:0]                      pos;
        logic [`NUM_OF-1:0][`ACC_W-1:0]  acc;
    } acc_vec_t;

    typedef struct packed {
        logic                            valid;
        logic [5:0]                      pos;
        logic [`NUM_OF-1:0][`PIX_W-1:0]  data;
    } result_t;

    typedef enum logic [1:0] {ST_IDLE, ST_RUN, ST_DRAIN, ST_DONE} ctrl_state_e;

    typedef enum logic [2:0] {
        RG_CTRL, RG_QUANT, RG_BIAS, RG_WGT, RG_FRAME, RG_RES, RG_NONE
    } region_e;

endpackage

// ==== hdl/axil_regs.sv ====
`timescale 1ns/1ns
`include "conv_defs.svh"

module axil_regs (
    input  logic                  clk,
    input  logic                  rst,
    input  conv_pkg::axil_req_t   axil_req,
    output conv_pkg::axil_rsp_t   axil_rsp,
    input  logic                  busy,
    input  logic                  done,
    output logic                  start,
    output logic                  frame_we,
    output logic [5:0]            frame_idx,
    output logic [`PIX_W-1:0]     frame_pix,
    output conv_pkg::weight_set_t weights,
    output conv_pkg::bias_vec_t   biases,
    output conv_pkg::quant_cfg_t  quant,
    output logic [7:0]            res_addr,
    input  logic [`PIX_W-1:0]     res_byte
);
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    function automatic conv_pkg::region_e decode(input logic [`ADDR_W-1:0] addr);
        conv_pkg::region_e rg;
        rg = conv_pkg::RG_NONE;
        if (addr == `REG_CTRL || addr == `REG_STATUS)
            rg = conv_pkg::RG_CTRL;
        else if (addr == `REG_QUANT)
            rg = conv_pkg::RG_QUANT;
        else if (addr >= `BIAS_BASE && addr < `BIAS_BASE + 12'h010)
            rg = conv_pkg::RG_BIAS;
        else if (addr >= `WGT_BASE && addr < `WGT_BASE + 12'h100 && addr[5:2] < 4'd9)
            rg = conv_pkg::RG_WGT;  // taps 9..15 of each channel are holes
        else if (addr >= `FRAME_BASE && addr < `FRAME_BASE + 12'h100)
            rg = conv_pkg::RG_FRAME;
        else if (addr >= `RES_BASE && addr < `RES_BASE + 12'h240)
            rg = conv_pkg::RG_RES;
        return rg;
    endfunction

    conv_pkg::region_e  wr_rg;
    conv_pkg::region_e  rd_rg;
    logic               wr_fire;
    logic               ar_fire;
    logic               cfg_wr;
    logic               bvalid_q;
    logic [1:0]         bresp_q;
    logic               rvalid_q;
    logic               rd_res_q;  // response carries a result byte
    logic [`DATA_W-1:0] rdata_q;
    logic [`ADDR_W-1:0] res_off;
    logic [7:0]         res_addr_q;

    assign wr_rg   = decode(axil_req.awaddr);
    assign rd_rg   = decode(axil_req.araddr);
    assign wr_fire = axil_req.awvalid && axil_req.wvalid && !bvalid_q;
    assign ar_fire = axil_req.arvalid && !rvalid_q;
    assign cfg_wr  = wr_rg inside {conv_pkg::RG_QUANT, conv_pkg::RG_BIAS,
                                   conv_pkg::RG_WGT, conv_pkg::RG_FRAME};

    ////////////////////////////////////////
    // write channel
    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid_q <= 1'b0;
            bresp_q  <= RESP_OKAY;
            start    <= 1'b0;
        end else begin
            start <= wr_fire && axil_req.awaddr == `REG_CTRL && axil_req.wdata[0] && !busy;
            if (wr_fire) begin
                bvalid_q <= 1'b1;
                bresp_q  <= (cfg_wr && busy) ? RESP_SLVERR : RESP_OKAY;
            end else if (axil_req.bready) begin
                bvalid_q <= 1'b0;
            end
        end
    end

    // config held steady while a run is on
    always_ff @(posedge clk) begin
        if (wr_fire && !busy) begin
            case (wr_rg)
                conv_pkg::RG_QUANT:
                    quant <= conv_pkg::quant_cfg_t'(axil_req.wdata[11:0]);
                conv_pkg::RG_BIAS:
                    biases[axil_req.awaddr[3:2]] <= axil_req.wdata[`BIAS_W-1:0];
                conv_pkg::RG_WGT:
                    weights[axil_req.awaddr[7:6]][axil_req.awaddr[5:2]] <=
                        axil_req.wdata[`PIX_W-1:0];
                default: ;
            endcase
        end
    end

    assign frame_we  = wr_fire && !busy && wr_rg == conv_pkg::RG_FRAME;
    assign frame_idx = axil_req.awaddr[7:2];
    assign frame_pix = axil_req.wdata[`PIX_W-1:0];

    ////////////////////////////////////////
    // read channel
    assign res_off  = axil_req.araddr - `RES_BASE;
    assign res_addr = ar_fire ? res_off[9:2] : res_addr_q;  // held so res_byte stays put

    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid_q <= 1'b0;
            rd_res_q <= 1'b0;
        end else if (ar_fire) begin
            rvalid_q <= 1'b1;
            rd_res_q <= rd_rg == conv_pkg::RG_RES;
        end else if (axil_req.rready) begin
            rvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_fire) begin
            res_addr_q <= res_off[9:2];
            case (rd_rg)
                conv_pkg::RG_CTRL:
                    rdata_q <= (axil_req.araddr == `REG_STATUS) ? {30'b0, done, busy} : '0;
                conv_pkg::RG_QUANT:
                    rdata_q <= `DATA_W'(quant);
                conv_pkg::RG_BIAS:
                    rdata_q <= `DATA_W'(biases[axil_req.araddr[3:2]]);
                conv_pkg::RG_WGT:
                    rdata_q <= `DATA_W'(weights[axil_req.araddr[7:6]][axil_req.araddr[5:2]]);
                default:
                    rdata_q <= '0;  // frame is write only
            endcase
        end
    end

    assign axil_rsp = '{
        awready: wr_fire,
        wready:  wr_fire,
        bvalid:  bvalid_q,
        bresp:   bresp_q,
        arready: ar_fire,
        rvalid:  rvalid_q,
        rdata:   rd_res_q ? `DATA_W'(res_byte) : rdata_q,
        rresp:   RESP_OKAY
    };

endmodule

// ==== hdl/conv_ctrl.sv ====
`timescale 1ns/1ns
`include "conv_defs.svh"

module conv_ctrl (
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  logic       last_result,
    output logic       busy,
    output logic       done,
    output logic       step,
    output logic [2:0] row,
    output logic [2:0] col
);
    conv_pkg::ctrl_state_e state;
    logic                  last_step;

    assign last_step = col == 3'(`IMG_W-1) && row == 3'(`OUT_W-1);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= conv_pkg::ST_IDLE;
            row   <= '0;
            col   <= '0;
        end else begin
            case (state)
                conv_pkg::ST_IDLE, conv_pkg::ST_DONE: begin
                    row <= '0;
                    col <= '0;
                    if (start)
                        state <= conv_pkg::ST_RUN;
                end
                conv_pkg::ST_RUN: begin
                    col <= col + 3'd1;  // one image column per cycle, wraps at 8
                    if (col == 3'(`IMG_W-1))
                        row <= row + 3'd1;
                    if (last_step)
                        state <= conv_pkg::ST_DRAIN;
                end
                conv_pkg::ST_DRAIN: begin
                    // pipeline still holds the tail of the frame
                    if (last_result)
                        state <= conv_pkg::ST_DONE;
                end
                default: state <= conv_pkg::ST_IDLE;
            endcase
        end
    end

    assign step = state == conv_pkg::ST_RUN;
    assign busy = state == conv_pkg::ST_RUN || state == conv_pkg::ST_DRAIN;
    assign done = state == conv_pkg::ST_DONE;  // cleared by the next start

endmodule

// ==== hdl/window_gen.sv ====
`timescale 1ns/1ns
`include "conv_defs.svh"

module window_gen (
    input  logic              clk,
    input  logic              rst,
    input  logic              frame_we,
    input  logic [5:0]        frame_idx,
    input  logic [`PIX_W-1:0] frame_pix,
    input  logic              step,
    input  logic [2:0]        row,
    input  logic [2:0]        col,
    output conv_pkg::window_t win
);
    logic [`PIX_W-1:0]                frame [`IMG_W*`IMG_H];
    logic [`KSZ-1:0][`PIX_W-1:0]      fetch;  // one pixel per kernel row
    logic [`KSZ*`KSZ-1:0][`PIX_W-1:0] taps;
    logic                             valid_q;
    logic [5:0]                       pos_q;

    always_ff @(posedge clk) begin
        if (frame_we)
            frame[frame_idx] <= frame_pix;
    end

    // rows row..row+2 at the current column
    always_comb begin
        for (int r = 0; r < `KSZ; r++) begin
            fetch[r] = frame[{row + 3'(r), col}];
        end
    end

    ////////////////////////////////////////
    // 3x3 window, newest column on the right
    always_ff @(posedge clk) begin
        if (step) begin
            for (int r = 0; r < `KSZ; r++) begin
                for (int c = 0; c < `KSZ-1; c++) begin
                    taps[r*`KSZ + c] <= taps[r*`KSZ + c + 1];
                end
                taps[r*`KSZ + `KSZ-1] <= fetch[r];
            end
            pos_q <= 6'(row) * 6'(`OUT_W) + 6'(col) - 6'(`KSZ-1);
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            valid_q <= 1'b0;
        else
            valid_q <= step && col >= 3'(`KSZ-1);  // window full from column 2
    end

    assign win = '{valid: valid_q, pos: pos_q, pix: taps};

endmodule

// ==== hdl/mac_array.sv ====
`timescale 1ns/1ns
`include "conv_defs.svh"

module mac_array (
    input  logic                  clk,
    input  logic                  rst,
    input  conv_pkg::window_t     win,
    input  conv_pkg::weight_set_t weights,
    output conv_pkg::acc_vec_t    acc
);
    localparam int NTAP = `KSZ * `KSZ;
    localparam int PW   = 2 * `PIX_W + 1;  // unsigned pixel times signed weight

    logic signed [PW-1:0]           prod_q [`NUM_OF][NTAP];
    logic [`NUM_OF-1:0][`ACC_W-1:0] sum_d;
    logic [`NUM_OF-1:0][`ACC_W-1:0] sum_q;
    logic                           v1_q;
    logic                           v2_q;
    logic [5:0]                     pos1_q;
    logic [5:0]                     pos2_q;

    // stage 1, products for all four lanes
    always_ff @(posedge clk) begin
        for (int ch = 0; ch < `NUM_OF; ch++) begin
            for (int t = 0; t < NTAP; t++) begin
                prod_q[ch][t] <= PW'($signed({1'b0, win.pix[t]})) *
                                 PW'($signed(weights[ch][t]));
            end
        end
        pos1_q <= win.pos;
    end

    // stage 2, nine-tap adder tree per lane
    always_comb begin
        for (int ch = 0; ch < `NUM_OF; ch++) begin
            sum_d[ch] = '0;
            for (int t = 0; t < NTAP; t++) begin
                sum_d[ch] = sum_d[ch] + `ACC_W'(prod_q[ch][t]);
            end
        end
    end

    always_ff @(posedge clk) begin
        sum_q  <= sum_d;
        pos2_q <= pos1_q;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            v1_q <= 1'b0;
            v2_q <= 1'b0;
        end else begin
            v1_q <= win.valid;
            v2_q <= v1_q;
        end
    end

    assign acc = '{valid: v2_q, pos: pos2_q, acc: sum_q};

endmodule

// ==== hdl/requant.sv ====
`timescale 1ns/1ns
`include "conv_defs.svh"

module requant (
    input  logic                 clk,
    input  logic                 rst,
    input  conv_pkg::acc_vec_t   acc,
    input  conv_pkg::bias_vec_t  biases,
    input  conv_pkg::quant_cfg_t quant,
    output conv_pkg::result_t    res,
    output logic                 last_result
);
    localparam int BW = `ACC_W + 1;  // biased sum
    localparam int SW = BW + 9;      // times unsigned 8-bit scale

    function automatic logic [`PIX_W-1:0] scale_clamp(input logic [`ACC_W-1:0]  a,
                                                      input logic [`BIAS_W-1:0] b,
                                                      input conv_pkg::quant_cfg_t q);
        logic signed [BW-1:0] biased;
        logic signed [SW-1:0] scaled;
        biased = BW'($signed(a)) + BW'($signed(b));
        scaled = (SW'(biased) * SW'($signed({1'b0, q.scale}))) >>> q.shift;
        if (scaled[SW-1])
            return '0;  // negative
        else if (scaled > SW'(255))
            return '1;
        return scaled[`PIX_W-1:0];
    endfunction

    logic [`NUM_OF-1:0][`PIX_W-1:0] data_q;
    logic [5:0]                     pos_q;
    logic                           valid_q;

    always_ff @(posedge clk) begin
        for (int ch = 0; ch < `NUM_OF; ch++) begin
            data_q[ch] <= scale_clamp(acc.acc[ch], biases[ch], quant);
        end
        pos_q <= acc.pos;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q     <= 1'b0;
            last_result <= 1'b0;
        end else begin
            valid_q     <= acc.valid;
            last_result <= acc.valid && acc.pos == 6'(`OUT_W*`OUT_W - 1);
        end
    end

    assign res = '{valid: valid_q, pos: pos_q, data: data_q};

endmodule

// ==== hdl/result_store.sv ====
`timescale 1ns/1ns
`include "conv_defs.svh"

module result_store (
    input  logic              clk,
    input  conv_pkg::result_t res,
    input  logic [7:0]        res_addr,  // pos*4 + channel
    output logic [`PIX_W-1:0] res_byte
);
    logic [`NUM_OF-1:0][`PIX_W-1:0] mem [`OUT_W*`OUT_W];

    always_ff @(posedge clk) begin
        if (res.valid)
            mem[res.pos] <= res.data;  // all four channels at once
        res_byte <= mem[res_addr[7:2]][res_addr[1:0]];
    end

endmodule

// ==== hdl/conv_top.sv ====
`timescale 1ns/1ns
`include "conv_defs.svh"

module conv_top (
    input  logic                clk,
    input  logic                rst,
    input  conv_pkg::axil_req_t axil_req,
    output conv_pkg::axil_rsp_t axil_rsp
);
    logic                   start;
    logic                   busy;
    logic                   done;
    logic                   step;
    logic [2:0]             row;
    logic [2:0]             col;
    logic                   last_result;
    logic                   frame_we;
    logic [5:0]             frame_idx;
    logic [`PIX_W-1:0]      frame_pix;
    logic [7:0]             res_addr;
    logic [`PIX_W-1:0]      res_byte;
    conv_pkg::weight_set_t  weights;
    conv_pkg::bias_vec_t    biases;
    conv_pkg::quant_cfg_t   quant;
    conv_pkg::window_t      win;
    conv_pkg::acc_vec_t     acc;
    conv_pkg::result_t      res;

    axil_regs u_axil_regs (
        .clk(clk), .rst(rst), .axil_req(axil_req), .axil_rsp(axil_rsp),
        .busy(busy), .done(done), .start(start),
        .frame_we(frame_we), .frame_idx(frame_idx), .frame_pix(frame_pix),
        .weights(weights), .biases(biases), .quant(quant),
        .res_addr(res_addr), .res_byte(res_byte)
    );

    conv_ctrl u_conv_ctrl (
        .clk(clk), .rst(rst), .start(start), .last_result(last_result),
        .busy(busy), .done(done), .step(step), .row(row), .col(col)
    );

    window_gen u_window_gen (
        .clk(clk), .rst(rst),
        .frame_we(frame_we), .frame_idx(frame_idx), .frame_pix(frame_pix),
        .step(step), .row(row), .col(col), .win(win)
    );

    mac_array u_mac_array (
        .clk(clk), .rst(rst), .win(win), .weights(weights), .acc(acc)
    );

    requant u_requant (
        .clk(clk), .rst(rst), .acc(acc), .biases(biases), .quant(quant),
        .res(res), .last_result(last_result)
    );

    result_store u_result_store (
        .clk(clk), .res(res), .res_addr(res_addr), .res_byte(res_byte)
    );

endmodule

// ==== verification/conv_checker.sv ====
`timescale 1ns/1ns

module conv_checker (
    input logic                clk,
    input logic                rst,
    input conv_pkg::axil_req_t axil_req,
    input conv_pkg::axil_rsp_t axil_rsp,
    input logic                busy,
    input logic                done
);
    int fail_count = 0;

    // responses held until the master takes them
    b_hold: assert property (@(posedge clk) disable iff (rst)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid && $stable(axil_rsp.bresp))
        else begin
            fail_count++;
            $error("bvalid or bresp changed before bready");
        end

    r_hold: assert property (@(posedge clk) disable iff (rst)
        axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid)
        else begin
            fail_count++;
            $error("rvalid dropped before rready");
        end

    one_state: assert property (@(posedge clk) disable iff (rst) !(busy && done))
        else begin
            fail_count++;
            $error("busy and done high together");
        end

    // first cycle out of reset
    quiet_after_rst: assert property (@(posedge clk)
        rst |=> !axil_rsp.bvalid && !axil_rsp.rvalid)
        else begin
            fail_count++;
            $error("response valid right after reset");
        end

endmodule

bind conv_top conv_checker u_conv_checker (
    .clk(clk), .rst(rst), .axil_req(axil_req), .axil_rsp(axil_rsp),
    .busy(busy), .done(done)
);

// ==== verification/tb_conv.sv ====
`timescale 1ns/1ns
`include "conv_defs.svh"

module tb_conv;
    localparam int TIMEOUT_CYCLES = 20000;  // six tests need about 7000
    localparam logic [1:0] OKAY   = 2'b00;
    localparam logic [1:0] SLVERR = 2'b10;

    logic                clk;
    logic                rst;
    conv_pkg::axil_req_t req;
    conv_pkg::axil_rsp_t rsp;
    int                  errors;
    int                  checks;
    int                  cycles;
    int                  seed;

    // reference model state
    logic [`PIX_W-1:0]   frame_m [`IMG_W*`IMG_H];
    logic [`PIX_W-1:0]   wgt_m [`NUM_OF][`KSZ*`KSZ];  // signed
    logic [`BIAS_W-1:0]  bias_m [`NUM_OF];
    logic [7:0]          scale_m;
    logic [3:0]          shift_m;
    logic [`PIX_W-1:0]   exp_m [`OUT_W*`OUT_W][`NUM_OF];

    conv_top u_conv_top (.clk(clk), .rst(rst), .axil_req(req), .axil_rsp(rsp));

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, a bus response or done never came", cycles);
        $display("Verification failed");
        $finish;
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Error %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    ////////////////////////////////////////
    // bus tasks drive on the rising edge and sample on the falling edge
    task automatic axil_write(input string name, input logic [11:0] addr,
                              input logic [31:0] data, input int delay,
                              output logic [1:0] resp);
        @(posedge clk);
        req.awaddr  <= addr;
        req.awvalid <= 1'b1;
        req.wdata   <= data;
        req.wvalid  <= 1'b1;
        @(negedge clk);
        while (!rsp.awready) @(negedge clk);
        check({name, " wready"}, 32'd1, 32'(rsp.wready));
        @(posedge clk);
        req.awvalid <= 1'b0;
        req.wvalid  <= 1'b0;
        @(negedge clk);
        while (!rsp.bvalid) @(negedge clk);
        resp = rsp.bresp;
        repeat (delay) begin  // bready held off
            @(negedge clk);
            check({name, " bvalid held"}, 32'd1, 32'(rsp.bvalid));
            check({name, " bresp held"}, 32'(resp), 32'(rsp.bresp));
        end
        @(posedge clk);
        req.bready <= 1'b1;
        @(posedge clk);
        req.bready <= 1'b0;
    endtask

    task automatic axil_read(input string name, input logic [11:0] addr, input int delay,
                             output logic [31:0] data, output logic [1:0] resp);
        @(posedge clk);
        req.araddr  <= addr;
        req.arvalid <= 1'b1;
        @(negedge clk);
        while (!rsp.arready) @(negedge clk);
        @(posedge clk);
        req.arvalid <= 1'b0;
        @(negedge clk);
        while (!rsp.rvalid) @(negedge clk);
        data = rsp.rdata;
        resp = rsp.rresp;
        repeat (delay) begin
            @(negedge clk);
            check({name, " rvalid held"}, 32'd1, 32'(rsp.rvalid));
            check({name, " rdata held"}, data, rsp.rdata);
        end
        @(posedge clk);
        req.rready <= 1'b1;
        @(posedge clk);
        req.rready <= 1'b0;
    endtask

    task automatic write_ok(input string name, input logic [11:0] addr,
                            input logic [31:0] data, input int delay);
        logic [1:0] resp;
        axil_write(name, addr, data, delay, resp);
        check({name, " bresp"}, 32'(OKAY), 32'(resp));
    endtask

    task automatic read_word(input string name, input logic [11:0] addr, input int delay,
                             output logic [31:0] data);
        logic [1:0] resp;
        axil_read(name, addr, delay, data, resp);
        check({name, " rresp"}, 32'(OKAY), 32'(resp));
    endtask

    ////////////////////////////////////////
    // model setup and loading
    task automatic random_frame();
        for (int i = 0; i < `IMG_W*`IMG_H; i++)
            frame_m[i] = 8'($random(seed));
    endtask

    task automatic random_weights();
        for (int ch = 0; ch < `NUM_OF; ch++)
            for (int t = 0; t < `KSZ*`KSZ; t++)
                wgt_m[ch][t] = 8'($random(seed));
    endtask

    task automatic load_config(input string name, input int delay);
        for (int ch = 0; ch < `NUM_OF; ch++) begin
            for (int t = 0; t < `KSZ*`KSZ; t++)
                write_ok(name, `WGT_BASE + 12'(ch * 'h40 + t * 4), 32'(wgt_m[ch][t]), delay);
            write_ok(name, `BIAS_BASE + 12'(ch * 4), 32'(bias_m[ch]), delay);
        end
        write_ok(name, `REG_QUANT, {20'b0, shift_m, scale_m}, delay);
    endtask

    task automatic load_frame(input string name, input int delay);
        for (int i = 0; i < `IMG_W*`IMG_H; i++)
            write_ok(name, `FRAME_BASE + 12'(i * 4), 32'(frame_m[i]), delay);
    endtask

    // pixel times weight over 9 taps, plus bias, times scale, shift, clamp
    task automatic compute_expected();
        int acc;
        for (int pos = 0; pos < `OUT_W*`OUT_W; pos++) begin
            for (int ch = 0; ch < `NUM_OF; ch++) begin
                acc = int'($signed(bias_m[ch]));
                for (int t = 0; t < `KSZ*`KSZ; t++)
                    acc += int'(frame_m[(pos / 6 + t / 3) * 8 + pos % 6 + t % 3]) *
                           int'($signed(wgt_m[ch][t]));
                acc = (acc * int'(scale_m)) >>> shift_m;
                exp_m[pos][ch] = acc < 0 ? 8'd0 : (acc > 255 ? 8'd255 : 8'(acc));
            end
        end
    endtask

    task automatic start_run(input string name);
        write_ok(name, `REG_CTRL, 32'd1, 0);
    endtask

    task automatic wait_done(input string name);
        logic [31:0] status;
        status = '0;
        while (!status[1])
            read_word(name, `REG_STATUS, 0, status);
        check({name, " status"}, 32'h2, status);  // done, not busy
    endtask

    task automatic check_results(input string name, input int delay);
        logic [31:0] data;
        for (int pos = 0; pos < `OUT_W*`OUT_W; pos++) begin
            for (int ch = 0; ch < `NUM_OF; ch++) begin
                read_word(name, `RES_BASE + 12'((pos * 4 + ch) * 4), delay, data);
                check(name, 32'(exp_m[pos][ch]), data);
            end
        end
    endtask

    ////////////////////////////////////////
    // directed tests
    task automatic test_readback();
        logic [31:0] data;
        random_weights();
        bias_m  = '{16'hfa24, 16'h0100, 16'h7fff, 16'h8000};
        scale_m = 8'd77;
        shift_m = 4'd3;
        load_config("readback", 0);
        for (int ch = 0; ch < `NUM_OF; ch++) begin
            read_word("readback", `BIAS_BASE + 12'(ch * 4), 0, data);
            check("readback bias", 32'(bias_m[ch]), data);
            read_word("readback", `WGT_BASE + 12'(ch * 'h40 + (2 * ch + 1) * 4), 0, data);
            check("readback weight", 32'(wgt_m[ch][2 * ch + 1]), data);
        end
        read_word("readback", `REG_QUANT, 0, data);
        check("readback quant", {20'b0, shift_m, scale_m}, data);
        read_word("readback", 12'h0c0, 0, data);
        check("readback unmapped", 32'd0, data);
        read_word("readback", 12'h13c, 0, data);  // weight tap hole
        check("readback hole", 32'd0, data);
    endtask

    task automatic test_known_conv();
        for (int i = 0; i < `IMG_W*`IMG_H; i++)
            frame_m[i] = 8'd1;
        for (int ch = 0; ch < `NUM_OF; ch++) begin
            bias_m[ch] = '0;
            for (int t = 0; t < `KSZ*`KSZ; t++)
                wgt_m[ch][t] = 8'd1;
        end
        scale_m = 8'd1;
        shift_m = 4'd0;
        load_config("known_conv", 0);
        load_frame("known_conv", 0);
        for (int pos = 0; pos < `OUT_W*`OUT_W; pos++)
            for (int ch = 0; ch < `NUM_OF; ch++)
                exp_m[pos][ch] = 8'd9;  // nine ones times one
        start_run("known_conv");
        wait_done("known_conv");
        check_results("known_conv", 0);
    endtask

    task automatic test_random_conv();
        int n_lo;
        int n_hi;
        random_frame();
        random_weights();
        bias_m  = '{16'(-1500), 16'(2500), 16'(-300), 16'(700)};
        scale_m = 8'd5;
        shift_m = 4'd9;
        load_config("random_conv", 0);
        load_frame("random_conv", 0);
        compute_expected();
        n_lo = 0;
        n_hi = 0;
        for (int pos = 0; pos < `OUT_W*`OUT_W; pos++) begin
            for (int ch = 0; ch < `NUM_OF; ch++) begin
                n_lo += int'(exp_m[pos][ch] == 8'd0);
                n_hi += int'(exp_m[pos][ch] == 8'd255);
            end
        end
        check("random_conv clamp low seen", 32'd1, 32'(n_lo > 0));
        check("random_conv clamp high seen", 32'd1, 32'(n_hi > 0));
        start_run("random_conv");
        wait_done("random_conv");
        check_results("random_conv", 0);
    endtask

    task automatic test_busy_write();
        logic [31:0] data;
        logic [1:0]  resp;
        start_run("busy_write");
        read_word("busy_write", `REG_STATUS, 0, data);
        check("busy_write status", 32'h1, data);
        axil_write("busy_write", `FRAME_BASE + 12'(10 * 4), 32'(~frame_m[10]), 0, resp);
        check("busy_write frame bresp", 32'(SLVERR), 32'(resp));
        axil_write("busy_write", `WGT_BASE + 12'(2 * 'h40 + 4 * 4), 32'(~wgt_m[2][4]), 0, resp);
        check("busy_write weight bresp", 32'(SLVERR), 32'(resp));
        wait_done("busy_write");
        check_results("busy_write", 0);
        read_word("busy_write", `WGT_BASE + 12'(2 * 'h40 + 4 * 4), 0, data);
        check("busy_write weight kept", 32'(wgt_m[2][4]), data);
    endtask

    task automatic test_backpressure();
        random_frame();
        load_frame("backpressure", 3);
        compute_expected();
        start_run("backpressure");
        wait_done("backpressure");
        check_results("backpressure", 5);
    endtask

    task automatic test_restart();
        logic [31:0] data;
        random_frame();
        load_frame("restart", 0);
        compute_expected();
        read_word("restart", `REG_STATUS, 0, data);
        check("restart done before start", 32'h2, data);
        start_run("restart");
        read_word("restart", `REG_STATUS, 0, data);
        check("restart busy after start", 32'h1, data);  // done cleared
        wait_done("restart");
        check_results("restart", 0);
    endtask

    initial begin
        seed   = 46138;
        errors = 0;
        checks = 0;
        rst    = 1'b1;
        req    = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        test_readback();
        test_known_conv();
        test_random_conv();
        test_busy_write();
        test_backpressure();
        test_restart();
        errors += u_conv_top.u_conv_checker.fail_count;
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+include
hdl/conv_pkg.sv
hdl/axil_regs.sv
hdl/conv_ctrl.sv
hdl/window_gen.sv
hdl/mac_array.sv
hdl/requant.sv
hdl/result_store.sv
hdl/conv_top.sv
verification/conv_checker.sv
verification/tb_conv.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --assert -f tb.f --top-module tb_conv -o tb_conv_sim &&
./obj_dir/tb_conv_sim | grep "Verification passed" || exit 1
